//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = phy_lane_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/phy_clk_gen.sv
module phy_clk_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                     // 100 ns period.
    end

endmodule

//--- dv/phy_lane_tb.sv
module phy_lane_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int         ERR_LIMIT   = 4;
    localparam logic [7:0] COMMA_BYTE  = 8'hBC;
    localparam int         LOOP_NORMAL = 0;
    localparam int         LOOP_SLIP   = 1;
    localparam int         LOOP_ZERO   = 2;
    localparam int         WAIT_LIMIT  = 400;       // cycles.

    logic       clk;
    logic       rst     = 1'b1;
    logic [7:0] tx_data = COMMA_BYTE;
    logic       tx_k    = 1'b1;
    logic       ser_in  = 1'b0;
    logic       tx_ready;
    logic       ser_out;
    logic       rx_k;
    logic       rx_err;
    logic       rx_valid;
    logic       rx_locked;
    logic [7:0] rx_data;
    logic       loop_q    = 1'b0;
    int         loop_mode = LOOP_NORMAL;
    logic       check_en  = 1'b0;
    logic       in_sync   = 1'b0;
    logic [8:0] exp_q[$];                           // {k, byte} in send order.
    logic [8:0] exp_sym;
    int         seed = 32'h46c613bf;

    phy_clk_gen phy_clk_gen_inst (.clk(clk));

    phy_lane_top #(
        .ERR_LIMIT (ERR_LIMIT)
    ) phy_lane_top_inst (
        .CLK       (clk),
        .rst       (rst),
        .tx_data   (tx_data),
        .tx_k      (tx_k),
        .ser_in    (ser_in),
        .tx_ready  (tx_ready),
        .ser_out   (ser_out),
        .rx_data   (rx_data),
        .rx_k      (rx_k),
        .rx_err    (rx_err),
        .rx_valid  (rx_valid),
        .rx_locked (rx_locked)
    );

    // serial loopback, normal, one bit slipped or stuck at zero
    always @(posedge clk) begin
        loop_q <= ser_out;
        case (loop_mode)
            LOOP_SLIP: ser_in <= loop_q;            // one extra bit of delay.
            LOOP_ZERO: ser_in <= 1'b0;
            default:   ser_in <= ser_out;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checking helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic report_failure();
        $display("Simulation FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH time=%0t %s expected=0x%0h actual=0x%0h",
                     $time, name, expected, actual);
            report_failure();
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        report_failure();
    endtask

    // idle commas are skipped until the first queued byte shows up
    always @(posedge clk) begin
        if (check_en && rx_valid) begin
            check_val("rx_err", 0, rx_err);
            if (in_sync || !rx_k) begin
                assert (exp_q.size() != 0) else begin
                    $display("received data 0x%0h at %0t with nothing sent", rx_data, $time);
                    report_failure();
                end
                exp_sym = exp_q.pop_front();
                check_val("rx_k", exp_sym[8], rx_k);
                check_val("rx_data", exp_sym[7:0], rx_data);
                in_sync = (exp_q.size() != 0);
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // waits and drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic wait_tx_ready();
        int n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > 20) fail_timeout("tx_ready");
        end while (!tx_ready);
    endtask

    task automatic wait_rx_valid();
        int n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) fail_timeout("rx_valid");
        end while (!rx_valid);
    endtask

    task automatic wait_locked(input logic level);
        int n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) fail_timeout("rx_locked change");
        end while (rx_locked !== level);
    endtask

    task automatic wait_drained();
        int n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) fail_timeout("receive queue to drain");
        end
    endtask

    // value driven at a pulse is sampled at the next pulse
    task automatic send_symbol(input logic k, input logic [7:0] data);
        wait_tx_ready();
        tx_k    <= k;
        tx_data <= k ? COMMA_BYTE : data;
        exp_q.push_back({k, k ? COMMA_BYTE : data});
    endtask

    task automatic send_idle();
        wait_tx_ready();
        tx_k    <= 1'b1;
        tx_data <= COMMA_BYTE;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic test_reset_state();
        int   cyc = 0;
        int   last_pulse = 0;
        int   pulses = 0;
        logic locked_seen = 1'b0;
        logic valid_seen = 1'b0;
        while (!(valid_seen && pulses >= 4)) begin
            @(posedge clk);
            cyc++;
            if (cyc > WAIT_LIMIT) fail_timeout("first comma after reset");
            if (cyc == 1) check_val("rx_locked", 0, rx_locked);
            locked_seen = locked_seen | rx_locked;
            if (tx_ready) begin
                if (pulses == 0) begin
                    assert (cyc <= 10) else begin
                        $display("tx_ready did not pulse within 10 cycles of reset release");
                        report_failure();
                    end
                end else begin
                    check_val("tx_ready period", 10, cyc - last_pulse);
                end
                last_pulse = cyc;
                pulses++;
            end
            if (!valid_seen) begin
                check_val("rx_err", 0, rx_err);
                if (rx_valid) begin
                    valid_seen = 1'b1;
                    check_val("rx_locked", 1, locked_seen);
                    check_val("rx_k", 1, rx_k);
                    check_val("rx_data", COMMA_BYTE, rx_data);
                end
            end
        end
    endtask

    task automatic test_comma_lock();
        wait_locked(1'b1);
        repeat (5) begin
            wait_rx_valid();
            check_val("rx_k", 1, rx_k);
            check_val("rx_data", COMMA_BYTE, rx_data);
            check_val("rx_err", 0, rx_err);
        end
    endtask

    task automatic test_all_bytes();
        check_en <= 1'b1;
        for (int b = 0; b < 256; b++) send_symbol(1'b0, 8'(b));
        send_idle();
        wait_drained();
    endtask

    task automatic test_random_mix();
        int         sent = 0;
        logic [31:0] r;
        while (sent < 200) begin
            r = $random(seed);
            if (sent > 0 && r[2:0] == 3'd0) begin
                send_symbol(1'b1, COMMA_BYTE);      // comma in a random slot.
            end else begin
                send_symbol(1'b0, r[15:8]);
                sent++;
            end
        end
        send_idle();
        wait_drained();
    endtask

    task automatic test_loss_of_lock();
        int n = 0;
        int errs = 0;
        check_en  <= 1'b0;
        loop_mode <= LOOP_ZERO;
        while (rx_locked) begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) fail_timeout("loss of lock");
            if (rx_valid && rx_err) errs++;
        end
        check_val("rx_err count at unlock", ERR_LIMIT, errs);
        loop_mode <= LOOP_NORMAL;
        wait_locked(1'b1);
    endtask

    task automatic test_bit_slip();
        loop_mode <= LOOP_SLIP;
        wait_locked(1'b0);
        wait_locked(1'b1);
        wait_rx_valid();
        check_val("rx_k after relock", 1, rx_k);
        check_en <= 1'b1;
        for (int i = 0; i < 40; i++) send_symbol(1'b0, 8'($random(seed)));
        send_idle();
        wait_drained();
    endtask

    initial begin
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_comma_lock();
        test_all_bytes();
        test_random_mix();
        test_loss_of_lock();
        test_bit_slip();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- flist.f
verilog/phy_types_pkg.sv
verilog/enc_8b10b.sv
verilog/lane_serializer.sv
verilog/comma_aligner.sv
verilog/dec_8b10b.sv
verilog/phy_lane_top.sv
dv/phy_clk_gen.sv
dv/phy_lane_tb.sv

//--- verilog/comma_aligner.sv
module comma_aligner #(
    parameter int ERR_LIMIT = 4
) (
    input  logic                              CLK,
    input  logic                              rst,
    input  logic                              ser_in,
    input  logic                              code_err,
    output logic [phy_types_pkg::SYM_BITS-1:0] sym,
    output logic                              sym_strobe,
    output logic                              locked
);
    import phy_types_pkg::*;

    localparam int CNT_W = $clog2(ERR_LIMIT + 1);
    localparam logic [3:0] LAST_SLOT = 4'(SYM_BITS - 1);
    // comma as it sits in the window, 6-bit field oldest.
    localparam logic [SYM_BITS-1:0] COMMA_WIN = {K28_5_CODE[5:0], K28_5_CODE[9:6]};

    align_state_e        state;
    logic [SYM_BITS-1:0] win;
    logic [3:0]          bnd_cnt;
    logic [CNT_W-1:0]    err_cnt;
    logic                err_chk;
    logic                comma_hit;
    logic                frame_hit;

    assign comma_hit = (win == COMMA_WIN);
    assign frame_hit = (state == HUNT) ? comma_hit : (bnd_cnt == LAST_SLOT);
    assign locked    = (state == LOCKED);

    always_ff @(posedge CLK) begin
        if (rst) begin
            win <= '0;
        end else begin
            win <= {win[SYM_BITS-2:0], ser_in};
        end
    end

    always_ff @(posedge CLK) begin
        if (frame_hit) begin
            sym <= {win[3:0], win[9:4]};            // back to {fghj, abcdei}.
        end
    end

    // decoder flag is valid the cycle after its strobe.
    always_ff @(posedge CLK) begin
        if (rst) begin
            sym_strobe <= 1'b0;
            err_chk    <= 1'b0;
        end else begin
            sym_strobe <= frame_hit;
            err_chk    <= sym_strobe;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lock FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge CLK) begin
        if (rst) begin
            state   <= HUNT;
            bnd_cnt <= '0;
            err_cnt <= '0;
        end else begin
            case (state)
                HUNT: begin
                    if (comma_hit) begin
                        state   <= LOCKED;
                        bnd_cnt <= '0;
                        err_cnt <= '0;
                    end
                end
                LOCKED: begin
                    bnd_cnt <= frame_hit ? 4'd0 : bnd_cnt + 4'd1;
                    if (err_chk) begin
                        if (!code_err) begin
                            err_cnt <= '0;               // good symbol.
                        end else if (err_cnt == CNT_W'(ERR_LIMIT - 1)) begin
                            state   <= HUNT;
                            err_cnt <= '0;
                        end else begin
                            err_cnt <= err_cnt + 1'b1;
                        end
                    end
                end
                default: state <= HUNT;
            endcase
        end
    end

endmodule

//--- verilog/dec_8b10b.sv
module dec_8b10b (
    input  logic                              CLK,
    input  logic                              rst,
    input  logic [phy_types_pkg::SYM_BITS-1:0] sym,
    input  logic                              sym_strobe,
    output logic [7:0]                        data_out,
    output logic                              k_out,
    output logic                              code_err,
    output logic                              valid
);
    import phy_types_pkg::*;

    logic [2:0] val_3b;
    logic [4:0] val_5b;
    logic       ok_3b;
    logic       ok_5b;
    logic       is_comma;
    logic       bad_sym;

    assign is_comma = (sym == K28_5_CODE);
    assign bad_sym  = !is_comma && !(ok_3b && ok_5b);

    always_comb begin
        ok_3b  = 1'b1;
        val_3b = 3'd0;
        case (sym[9:6])
            D3b0:    val_3b = 3'd0;
            D3b1:    val_3b = 3'd1;
            D3b2:    val_3b = 3'd2;
            D3b3:    val_3b = 3'd3;
            D3b4:    val_3b = 3'd4;
            D3b5:    val_3b = 3'd5;
            D3b6:    val_3b = 3'd6;
            D3b7:    val_3b = 3'd7;
            default: ok_3b  = 1'b0;
        endcase
    end

    always_comb begin
        ok_5b  = 1'b1;
        val_5b = 5'd0;
        case (sym[5:0])
            D5b0:    val_5b = 5'd0;
            D5b1:    val_5b = 5'd1;
            D5b2:    val_5b = 5'd2;
            D5b3:    val_5b = 5'd3;
            D5b4:    val_5b = 5'd4;
            D5b5:    val_5b = 5'd5;
            D5b6:    val_5b = 5'd6;
            D5b7:    val_5b = 5'd7;
            D5b8:    val_5b = 5'd8;
            D5b9:    val_5b = 5'd9;
            D5b10:   val_5b = 5'd10;
            D5b11:   val_5b = 5'd11;
            D5b12:   val_5b = 5'd12;
            D5b13:   val_5b = 5'd13;
            D5b14:   val_5b = 5'd14;
            D5b15:   val_5b = 5'd15;
            D5b16:   val_5b = 5'd16;
            D5b17:   val_5b = 5'd17;
            D5b18:   val_5b = 5'd18;
            D5b19:   val_5b = 5'd19;
            D5b20:   val_5b = 5'd20;
            D5b21:   val_5b = 5'd21;
            D5b22:   val_5b = 5'd22;
            D5b23:   val_5b = 5'd23;
            D5b24:   val_5b = 5'd24;
            D5b25:   val_5b = 5'd25;
            D5b26:   val_5b = 5'd26;
            D5b27:   val_5b = 5'd27;
            D5b28:   val_5b = 5'd28;
            D5b29:   val_5b = 5'd29;
            D5b30:   val_5b = 5'd30;
            D5b31:   val_5b = 5'd31;
            default: ok_5b  = 1'b0;             // includes the comma's 001111.
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            valid    <= 1'b0;
            k_out    <= 1'b0;
            code_err <= 1'b0;
        end else begin
            valid <= sym_strobe;
            if (sym_strobe) begin
                k_out    <= is_comma;
                code_err <= bad_sym;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (sym_strobe) begin
            if (is_comma) begin
                data_out <= K28_5_BYTE;
            end else if (bad_sym) begin
                data_out <= 8'h00;
            end else begin
                data_out <= {val_3b, val_5b};
            end
        end
    end

endmodule

//--- verilog/enc_8b10b.sv
module enc_8b10b (
    input  logic                              CLK,
    input  logic                              rst,
    input  logic                              load,
    input  logic [7:0]                        data_in,
    input  logic                              k_in,
    output logic [phy_types_pkg::SYM_BITS-1:0] data_out
);
    import phy_types_pkg::*;

    logic [3:0] code_4b;
    logic [5:0] code_6b;

    always_comb begin
        case (data_in[7:5])
            3'd0: code_4b = D3b0;
            3'd1: code_4b = D3b1;
            3'd2: code_4b = D3b2;
            3'd3: code_4b = D3b3;
            3'd4: code_4b = D3b4;
            3'd5: code_4b = D3b5;
            3'd6: code_4b = D3b6;
            3'd7: code_4b = D3b7;
        endcase
    end

    always_comb begin
        case (data_in[4:0])
            5'd0:  code_6b = D5b0;
            5'd1:  code_6b = D5b1;
            5'd2:  code_6b = D5b2;
            5'd3:  code_6b = D5b3;
            5'd4:  code_6b = D5b4;
            5'd5:  code_6b = D5b5;
            5'd6:  code_6b = D5b6;
            5'd7:  code_6b = D5b7;
            5'd8:  code_6b = D5b8;
            5'd9:  code_6b = D5b9;
            5'd10: code_6b = D5b10;
            5'd11: code_6b = D5b11;
            5'd12: code_6b = D5b12;
            5'd13: code_6b = D5b13;
            5'd14: code_6b = D5b14;
            5'd15: code_6b = D5b15;
            5'd16: code_6b = D5b16;
            5'd17: code_6b = D5b17;
            5'd18: code_6b = D5b18;
            5'd19: code_6b = D5b19;
            5'd20: code_6b = D5b20;
            5'd21: code_6b = D5b21;
            5'd22: code_6b = D5b22;
            5'd23: code_6b = D5b23;
            5'd24: code_6b = D5b24;
            5'd25: code_6b = D5b25;
            5'd26: code_6b = D5b26;
            5'd27: code_6b = D5b27;
            5'd28: code_6b = D5b28;
            5'd29: code_6b = D5b29;
            5'd30: code_6b = D5b30;
            5'd31: code_6b = D5b31;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            data_out <= K28_5_CODE;                 // idle on comma.
        end else if (load) begin
            if (k_in) begin
                data_out <= K28_5_CODE;
            end else begin
                data_out <= {code_4b, code_6b};
            end
        end
    end

endmodule

//--- verilog/lane_serializer.sv
module lane_serializer (
    input  logic                              CLK,
    input  logic                              rst,
    input  logic [phy_types_pkg::SYM_BITS-1:0] sym,
    output logic                              tx_ready,
    output logic                              ser_out
);
    import phy_types_pkg::*;

    localparam logic [3:0] LAST_SLOT = 4'(SYM_BITS - 1);

    logic [3:0]          slot_cnt;
    logic [SYM_BITS-1:0] shreg;

    assign tx_ready = (slot_cnt == LAST_SLOT);      // last cycle of the slot.

    always_ff @(posedge CLK) begin
        if (rst) begin
            slot_cnt <= '0;
        end else if (slot_cnt == LAST_SLOT) begin
            slot_cnt <= '0;
        end else begin
            slot_cnt <= slot_cnt + 4'd1;
        end
    end

    // 6-bit field leaves first, then the 4-bit field, both msb first
    always_ff @(posedge CLK) begin
        if (rst) begin
            shreg   <= '0;
            ser_out <= 1'b0;
        end else begin
            ser_out <= shreg[SYM_BITS-1];
            if (slot_cnt == 4'd0) begin
                shreg <= {sym[5:0], sym[9:6]};      // encoder output settled.
            end else begin
                shreg <= {shreg[SYM_BITS-2:0], 1'b0};
            end
        end
    end

endmodule

//--- verilog/phy_lane_top.sv
module phy_lane_top #(
    parameter int ERR_LIMIT = 4
) (
    input  logic       CLK,
    input  logic       rst,
    input  logic [7:0] tx_data,
    input  logic       tx_k,
    input  logic       ser_in,
    output logic       tx_ready,
    output logic       ser_out,
    output logic [7:0] rx_data,
    output logic       rx_k,
    output logic       rx_err,
    output logic       rx_valid,
    output logic       rx_locked
);
    import phy_types_pkg::*;

    logic [SYM_BITS-1:0] enc_sym;
    logic [SYM_BITS-1:0] al_sym;
    logic                al_strobe;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transmit path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    enc_8b10b enc_8b10b_inst (
        .CLK      (CLK),
        .rst      (rst),
        .load     (tx_ready),                   // sampled once per slot.
        .data_in  (tx_data),
        .k_in     (tx_k),
        .data_out (enc_sym)
    );

    lane_serializer lane_serializer_inst (
        .CLK      (CLK),
        .rst      (rst),
        .sym      (enc_sym),
        .tx_ready (tx_ready),
        .ser_out  (ser_out)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // receive path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    comma_aligner #(
        .ERR_LIMIT (ERR_LIMIT)
    ) comma_aligner_inst (
        .CLK        (CLK),
        .rst        (rst),
        .ser_in     (ser_in),
        .code_err   (rx_err),                   // decoder feedback.
        .sym        (al_sym),
        .sym_strobe (al_strobe),
        .locked     (rx_locked)
    );

    dec_8b10b dec_8b10b_inst (
        .CLK        (CLK),
        .rst        (rst),
        .sym        (al_sym),
        .sym_strobe (al_strobe),
        .data_out   (rx_data),
        .k_out      (rx_k),
        .code_err   (rx_err),
        .valid      (rx_valid)
    );

endmodule

//--- verilog/phy_types_pkg.sv
package phy_types_pkg;

    localparam int SYM_BITS = 10;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 3b/4b codes, written fghj, negative-disparity column
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [3:0] D3b0 = 4'b1011;
    localparam logic [3:0] D3b1 = 4'b1001;
    localparam logic [3:0] D3b2 = 4'b0101;
    localparam logic [3:0] D3b3 = 4'b1100;
    localparam logic [3:0] D3b4 = 4'b1101;
    localparam logic [3:0] D3b5 = 4'b1010;
    localparam logic [3:0] D3b6 = 4'b0110;
    localparam logic [3:0] D3b7 = 4'b1110;   // primary form only.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 5b/6b codes, written abcdei, negative-disparity column
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [5:0] D5b0  = 6'b100111;
    localparam logic [5:0] D5b1  = 6'b011101;
    localparam logic [5:0] D5b2  = 6'b101101;
    localparam logic [5:0] D5b3  = 6'b110001;
    localparam logic [5:0] D5b4  = 6'b110101;
    localparam logic [5:0] D5b5  = 6'b101001;
    localparam logic [5:0] D5b6  = 6'b011001;
    localparam logic [5:0] D5b7  = 6'b111000;
    localparam logic [5:0] D5b8  = 6'b111001;
    localparam logic [5:0] D5b9  = 6'b100101;
    localparam logic [5:0] D5b10 = 6'b010101;
    localparam logic [5:0] D5b11 = 6'b110100;
    localparam logic [5:0] D5b12 = 6'b001101;
    localparam logic [5:0] D5b13 = 6'b101100;
    localparam logic [5:0] D5b14 = 6'b011100;
    localparam logic [5:0] D5b15 = 6'b010111;
    localparam logic [5:0] D5b16 = 6'b011011;
    localparam logic [5:0] D5b17 = 6'b100011;
    localparam logic [5:0] D5b18 = 6'b010011;
    localparam logic [5:0] D5b19 = 6'b110010;
    localparam logic [5:0] D5b20 = 6'b001011;
    localparam logic [5:0] D5b21 = 6'b101010;
    localparam logic [5:0] D5b22 = 6'b011010;
    localparam logic [5:0] D5b23 = 6'b111010;
    localparam logic [5:0] D5b24 = 6'b110011;
    localparam logic [5:0] D5b25 = 6'b100110;
    localparam logic [5:0] D5b26 = 6'b010110;
    localparam logic [5:0] D5b27 = 6'b110110;
    localparam logic [5:0] D5b28 = 6'b001110;
    localparam logic [5:0] D5b29 = 6'b101110;
    localparam logic [5:0] D5b30 = 6'b011110;
    localparam logic [5:0] D5b31 = 6'b101011;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // comma and aligner state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // K28.5 laid out as {fghj, abcdei}, same as a data symbol.
    localparam logic [SYM_BITS-1:0] K28_5_CODE = {4'b1010, 6'b001111};
    localparam logic [7:0]          K28_5_BYTE = 8'hBC;

    typedef enum logic {
        HUNT   = 1'b0,
        LOCKED = 1'b1
    } align_state_e;

endpackage
